// ==== verilog/soc_pkg.sv ====
package soc_pkg;

    // address map
    localparam logic [15:0] rom_base = 16'hF000;
    localparam logic [15:0] io_base = 16'hF800;

    // device sizes, both mirrored across their regions
    localparam int unsigned ram_words = 1024;
    localparam int unsigned rom_words = 256;

    // io slot taken from adr[10:8], all other slots go to the leds
    localparam logic [2:0] timer_slot = 3'd5;

    // master to device
    typedef struct packed {
        logic [15:0] adr;
        logic [7:0]  dat;
        logic        we;
        logic        stb;
    } bus_req_t;

    // device to master
    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        DEV_RAM,
        DEV_ROM,
        DEV_LED,
        DEV_TIMER
    } dev_sel_e;

    // timer register offsets, adr[1:0]
    typedef enum logic [1:0] {
        TMR_COUNT,
        TMR_COMPARE,
        TMR_CTRL,
        TMR_STATUS
    } timer_reg_e;

endpackage

// ==== verilog/bus_decoder.sv ====
module bus_decoder import soc_pkg::*; (
    input  bus_req_t host_req_i,
    output bus_rsp_t host_rsp_o,

    output bus_req_t ram_req_o,
    output bus_req_t rom_req_o,
    output bus_req_t led_req_o,
    output bus_req_t tmr_req_o,

    input  bus_rsp_t ram_rsp_i,
    input  bus_rsp_t rom_rsp_i,
    input  bus_rsp_t led_rsp_i,
    input  bus_rsp_t tmr_rsp_i
);

    dev_sel_e   sel;
    logic [4:0] region;
    logic [2:0] slot;

    assign region = host_req_i.adr[15:11];
    assign slot = host_req_i.adr[10:8];

    // address decode
    always_comb begin
        if (region == rom_base[15:11]) begin
            sel = DEV_ROM;
        end else if (region == io_base[15:11]) begin
            if (slot == timer_slot) begin
                sel = DEV_TIMER;
            end else begin
                // unused io slots alias the led port
                sel = DEV_LED;
            end
        end else begin
            sel = DEV_RAM;
        end
    end

    // every device sees the address and data, only one gets the strobe
    always_comb begin
        ram_req_o = host_req_i;
        rom_req_o = host_req_i;
        led_req_o = host_req_i;
        tmr_req_o = host_req_i;

        ram_req_o.stb = host_req_i.stb && (sel == DEV_RAM);
        rom_req_o.stb = host_req_i.stb && (sel == DEV_ROM);
        led_req_o.stb = host_req_i.stb && (sel == DEV_LED);
        tmr_req_o.stb = host_req_i.stb && (sel == DEV_TIMER);
    end

    // response return
    always_comb begin
        case (sel)
            DEV_RAM: begin
                host_rsp_o = ram_rsp_i;
            end
            DEV_ROM: begin
                host_rsp_o = rom_rsp_i;
            end
            DEV_LED: begin
                host_rsp_o = led_rsp_i;
            end
            default: begin
                host_rsp_o = tmr_rsp_i;
            end
        endcase
    end

    strobe_onehot: assert final ($onehot0({ram_req_o.stb, rom_req_o.stb,
                                           led_req_o.stb, tmr_req_o.stb}))
        else $error("more than one device strobed at adr %h", host_req_i.adr);

endmodule

// ==== verilog/scratch_ram.sv ====
module scratch_ram import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o
);

    logic [7:0] mem [ram_words];
    logic [$clog2(ram_words)-1:0] idx;
    logic [7:0] rdata_q;
    logic       ack_q;
    logic       access;

    // mirrored by the low address bits
    assign idx = req_i.adr[$clog2(ram_words)-1:0];
    assign access = req_i.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                mem[idx] <= req_i.dat;
            end
            rdata_q <= mem[idx];
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;

    ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_q |=> !ack_q)
        else $error("ram ack held for two cycles");

endmodule

// ==== verilog/boot_rom.sv ====
module boot_rom import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o
);

    logic [7:0] mem [rom_words];
    logic [$clog2(rom_words)-1:0] idx;
    logic [7:0] rdata_q;
    logic       ack_q;
    logic       access;

    initial begin
        $readmemh("verilog/boot_rom.hex", mem);
    end

    assign idx = req_i.adr[$clog2(rom_words)-1:0];

    // writes are acked like reads and dropped
    assign access = req_i.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= mem[idx];
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;

    ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_q |=> !ack_q)
        else $error("rom ack held for two cycles");

endmodule

// ==== verilog/led_port.sv ====
module led_port import soc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  bus_req_t   req_i,
    output bus_rsp_t   rsp_o,
    output logic [7:0] leds_o
);

    logic [7:0] leds_q;
    logic       ack_q;
    logic       access;

    // one register behind every offset of every led slot
    assign access = req_i.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            leds_q <= 8'h00;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                leds_q <= req_i.dat;
            end
        end
    end

    // read back straight from the register
    assign rsp_o.dat = leds_q;
    assign rsp_o.ack = ack_q;
    assign leds_o = leds_q;

endmodule

// ==== verilog/tick_timer.sv ====
module tick_timer import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o,
    output logic     irq_o
);

    timer_reg_e reg_sel;
    logic [7:0] count_q;
    logic [7:0] compare_q;
    logic [7:0] rdata_q;
    logic       enable_q;
    logic       irq_en_q;
    logic       flag_q;
    logic       ack_q;
    logic       access;
    logic       wr;
    logic       hit;

    assign reg_sel = timer_reg_e'(req_i.adr[1:0]);
    assign access = req_i.stb && !ack_q;
    assign wr = access && req_i.we;

    // compare match, counter wraps to zero
    assign hit = enable_q && (count_q == compare_q);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= 8'h00;
        end else if (hit) begin
            count_q <= 8'h00;
        end else if (enable_q) begin
            count_q <= count_q + 8'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            compare_q <= 8'hFF;
            enable_q <= 1'b0;
            irq_en_q <= 1'b0;
            flag_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (wr && reg_sel == TMR_COMPARE) begin
                compare_q <= req_i.dat;
            end
            if (wr && reg_sel == TMR_CTRL) begin
                enable_q <= req_i.dat[0];
                irq_en_q <= req_i.dat[1];
            end
            // a new match wins over a clear in the same cycle
            if (hit) begin
                flag_q <= 1'b1;
            end else if (wr && reg_sel == TMR_STATUS && req_i.dat[0]) begin
                flag_q <= 1'b0;
            end
        end
    end

    // register read
    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_sel)
                TMR_COUNT:   rdata_q <= count_q;
                TMR_COMPARE: rdata_q <= compare_q;
                TMR_CTRL:    rdata_q <= {6'b0, irq_en_q, enable_q};
                default:     rdata_q <= {7'b0, flag_q};
            endcase
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;
    assign irq_o = flag_q && irq_en_q;

    // a control write with irq enable clear masks irq_o on the next edge
    irq_masked: assert property (@(posedge clk) disable iff (!rst_n_i)
        wr && reg_sel == TMR_CTRL && !req_i.dat[1] |=> !irq_o)
        else $error("irq_o high with irq enable clear");

endmodule

// ==== verilog/soc_top.sv ====
module soc_top import soc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  bus_req_t   host_req_i,
    output bus_rsp_t   host_rsp_o,
    output logic [7:0] leds_o,
    output logic       irq_o
);

    bus_req_t ram_req;
    bus_req_t rom_req;
    bus_req_t led_req;
    bus_req_t tmr_req;

    bus_rsp_t ram_rsp;
    bus_rsp_t rom_rsp;
    bus_rsp_t led_rsp;
    bus_rsp_t tmr_rsp;

    bus_decoder bus_decoder_inst (
        .host_req_i (host_req_i),
        .host_rsp_o (host_rsp_o),
        .ram_req_o  (ram_req),
        .rom_req_o  (rom_req),
        .led_req_o  (led_req),
        .tmr_req_o  (tmr_req),
        .ram_rsp_i  (ram_rsp),
        .rom_rsp_i  (rom_rsp),
        .led_rsp_i  (led_rsp),
        .tmr_rsp_i  (tmr_rsp)
    );

    scratch_ram scratch_ram_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (ram_req),
        .rsp_o   (ram_rsp)
    );

    boot_rom boot_rom_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (rom_req),
        .rsp_o   (rom_rsp)
    );

    led_port led_port_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (led_req),
        .rsp_o   (led_rsp),
        .leds_o  (leds_o)
    );

    // compare match interrupt goes straight out
    tick_timer tick_timer_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (tmr_req),
        .rsp_o   (tmr_rsp),
        .irq_o   (irq_o)
    );

endmodule

// ==== bench/soc_tb_tasks.svh ====
logic [7:0] ram_model [ram_words];
logic [7:0] rom_image [rom_words];
logic [7:0] led_model;

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// address map by range
function automatic dev_sel_e map_device(input logic [15:0] adr);
    if (adr < rom_base) begin
        return DEV_RAM;
    end else if (adr < io_base) begin
        return DEV_ROM;
    end else if (((adr - io_base) >> 8) == timer_slot) begin
        return DEV_TIMER;
    end
    return DEV_LED;
endfunction

function automatic logic [15:0] timer_adr(input timer_reg_e r);
    return io_base + {5'b0, timer_slot, 6'b0, r};
endfunction

function automatic logic [7:0] expected_read(input logic [15:0] adr);
    case (map_device(adr))
        DEV_RAM: return ram_model[adr % ram_words];
        DEV_ROM: return rom_image[adr % rom_words];
        default: return led_model;
    endcase
endfunction

// rom and timer writes leave the model alone
function automatic void model_write(input logic [15:0] adr, input logic [7:0] dat);
    case (map_device(adr))
        DEV_RAM: ram_model[adr % ram_words] = dat;
        DEV_LED: led_model = dat;
        default: ;
    endcase
endfunction

task automatic bus_access(input logic [15:0] adr, input logic [7:0] dat, input logic we,
                          output logic [7:0] rdata);
    int waited;
    waited = 0;
    rdata = 'x;
    @(negedge clk);
    host_req.adr = adr;
    host_req.dat = dat;
    host_req.we = we;
    host_req.stb = 1'b1;
    do begin
        @(negedge clk);
        waited++;
    end while (!host_rsp.ack && waited < ack_limit);
    if (host_rsp.ack) begin
        rdata = host_rsp.dat;
    end else begin
        errors++;
        $display("bus access to %h was never acknowledged", adr);
    end
    // idle cycle after the ack
    host_req.stb = 1'b0;
    host_req.we = 1'b0;
endtask

task automatic bus_write(input logic [15:0] adr, input logic [7:0] dat);
    logic [7:0] unused;
    bus_access(adr, dat, 1'b1, unused);
    model_write(adr, dat);
endtask

task automatic bus_read(input logic [15:0] adr, output logic [7:0] rdata);
    bus_access(adr, 8'h00, 1'b0, rdata);
endtask

task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
    assert (got === exp) else begin
        errors++;
        $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_read(input logic [15:0] adr);
    logic [7:0] got;
    bus_read(adr, got);
    check_value(got, expected_read(adr), $sformatf("read of %h", adr));
endtask

// ==== bench/soc_tb.sv ====
module soc_tb import soc_pkg::*; ();

    localparam int ram_writes = 32;
    localparam int rom_reads = 48;
    localparam int led_accesses = 12;
    localparam int timer_accesses = 56;
    localparam int ack_limit = 4;
    localparam int planned_accesses = 2 * ram_writes + rom_reads + 2 + led_accesses
                                      + timer_accesses;
    localparam int watchdog_cycles = 10 + 4 * planned_accesses * 2 + 44;
    localparam logic [2:0] led_slots [4] = '{3'd2, 3'd3, 3'd4, 3'd6};

    logic        clk;
    logic        rst_n_i;
    bus_req_t    host_req;
    bus_rsp_t    host_rsp;
    logic [7:0]  leds;
    logic        irq;

    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] lfsr_state;

    `include "soc_tb_tasks.svh"

    soc_top soc_top_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp),
        .leds_o     (leds),
        .irq_o      (irq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // every strobe is answered on the next edge
    ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
        host_req.stb |=> host_rsp.ack)
        else begin
            errors++;
            $display("ERR %0t: no ack in the cycle after stb", $time);
        end

    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
        host_rsp.ack |-> $past(host_req.stb))
        else begin
            errors++;
            $display("ERR %0t: ack without a preceding stb", $time);
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        host_rsp.ack |=> !host_rsp.ack)
        else begin
            errors++;
            $display("ERR %0t: ack high for two cycles", $time);
        end

    task automatic finish_test(input string name, input int base);
        if (errors == base) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - base);
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the test sequence hung", watchdog_cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int          base;
        int          compare;
        int          waited;
        logic [7:0]  got;
        logic [7:0]  dat;
        logic [15:0] adr;
        logic [15:0] written [$];

        host_req = '0;
        rst_n_i = 1'b0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        lfsr_state = 32'hfcaf32a8;
        led_model = 8'h00;
        $readmemh("verilog/boot_rom.hex", rom_image);
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;

        base = errors;
        check_value(host_rsp.ack, 8'h00, "ack after reset");
        check_value(irq, 8'h00, "irq_o after reset");
        check_value(leds, 8'h00, "leds_o after reset");
        check_read(rom_base);
        check_read(io_base);
        finish_test("protocol", base);

        base = errors;
        for (int i = 0; i < ram_writes; i++) begin
            adr = 16'(rand_bits(16) % rom_base);
            dat = 8'(rand_bits(8));
            bus_write(adr, dat);
            written.push_back(adr);
        end
        foreach (written[i]) begin
            // same low 10 bits, other upper bits
            adr = {6'(rand_bits(6) % 60), written[i][9:0]};
            check_read(adr);
        end
        finish_test("ram", base);

        base = errors;
        for (int i = 0; i < rom_reads; i++) begin
            check_read(16'(rom_base + rand_bits(11)));
        end
        adr = 16'(rom_base + rand_bits(11));
        bus_write(adr, ~expected_read(adr));
        check_read(adr);
        finish_test("rom", base);

        base = errors;
        dat = 8'(rand_bits(8));
        adr = io_base + 16'h0700 + 16'(rand_bits(8));
        bus_write(adr, dat);
        check_value(leds, dat, "leds_o after slot 7 write");
        check_read(adr);
        for (int i = 0; i < 4; i++) begin
            dat = 8'(rand_bits(8));
            bus_write(io_base + {5'b0, led_slots[i], 8'(rand_bits(8))}, dat);
            check_value(leds, dat, $sformatf("leds_o after slot %0d write", led_slots[i]));
            check_read(io_base + 16'(rand_bits(8)));
        end
        finish_test("led", base);

        base = errors;
        compare = 8 + int'(rand_bits(6) % 33);
        bus_write(timer_adr(TMR_COMPARE), 8'(compare));
        bus_read(timer_adr(TMR_COMPARE), got);
        check_value(got, 8'(compare), "timer compare");
        bus_write(timer_adr(TMR_CTRL), 8'h03);
        waited = 0;
        while (!irq && waited < compare + 4) begin
            @(negedge clk);
            waited++;
        end
        assert (irq) else begin
            errors++;
            $display("irq_o did not rise within %0d cycles of enabling the timer", compare + 4);
        end
        bus_read(timer_adr(TMR_STATUS), got);
        check_value(got, 8'h01, "timer status");
        bus_write(timer_adr(TMR_STATUS), 8'h01);
        check_value(irq, 8'h00, "irq_o after status clear");
        // interrupt masked, flag still sets
        bus_write(timer_adr(TMR_CTRL), 8'h01);
        got = 8'h00;
        waited = 0;
        while (got != 8'h01 && waited < compare + 4) begin
            bus_read(timer_adr(TMR_STATUS), got);
            check_value(irq, 8'h00, "irq_o with irq enable clear");
            waited++;
        end
        check_value(got, 8'h01, "timer status with irq masked");
        bus_write(timer_adr(TMR_CTRL), 8'h00);
        finish_test("timer", base);

        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog/boot_rom.hex ====
// boot rom image, eight bytes per line, addresses ascending from 00
// byte at address a is a ^ c3
C3 C2 C1 C0 C7 C6 C5 C4
CB CA C9 C8 CF CE CD CC
D3 D2 D1 D0 D7 D6 D5 D4
DB DA D9 D8 DF DE DD DC
E3 E2 E1 E0 E7 E6 E5 E4
EB EA E9 E8 EF EE ED EC
F3 F2 F1 F0 F7 F6 F5 F4
FB FA F9 F8 FF FE FD FC
83 82 81 80 87 86 85 84
8B 8A 89 88 8F 8E 8D 8C
93 92 91 90 97 96 95 94
9B 9A 99 98 9F 9E 9D 9C
A3 A2 A1 A0 A7 A6 A5 A4
AB AA A9 A8 AF AE AD AC
B3 B2 B1 B0 B7 B6 B5 B4
BB BA B9 B8 BF BE BD BC
43 42 41 40 47 46 45 44
4B 4A 49 48 4F 4E 4D 4C
53 52 51 50 57 56 55 54
5B 5A 59 58 5F 5E 5D 5C
63 62 61 60 67 66 65 64
6B 6A 69 68 6F 6E 6D 6C
73 72 71 70 77 76 75 74
7B 7A 79 78 7F 7E 7D 7C
03 02 01 00 07 06 05 04
0B 0A 09 08 0F 0E 0D 0C
13 12 11 10 17 16 15 14
1B 1A 19 18 1F 1E 1D 1C
23 22 21 20 27 26 25 24
2B 2A 29 28 2F 2E 2D 2C
33 32 31 30 37 36 35 34
3B 3A 39 38 3F 3E 3D 3C

// ==== vlog.f ====
+incdir+bench
verilog/soc_pkg.sv
verilog/bus_decoder.sv
verilog/scratch_ram.sv
verilog/boot_rom.sv
verilog/led_port.sv
verilog/tick_timer.sv
verilog/soc_top.sv
bench/soc_tb.sv
